//--- dual_issue_core.f
+incdir+testbench
logic/core_pkg.sv
logic/issue_lane_if.sv
logic/fetch_unit.sv
logic/decode_issue.sv
logic/alu_lane.sv
logic/data_memory.sv
logic/dual_issue_core.sv
testbench/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= dual_issue_core.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/core_tests.svh
localparam int num_directed = 7;

// One row per directed test with its checked register and final value
string           t_name     [num_directed];
logic [xlen-1:0] t_prog     [num_directed][prog_len];
int              t_reg      [num_directed];
logic [xlen-1:0] t_expected [num_directed];
int              t_pair     [num_directed];
logic [1:0]      t_port     [num_directed];

task automatic set_row(input int row, input string name, input int reg_idx,
                       input logic [xlen-1:0] expected, input int pair, input logic [1:0] port);
    t_name[row] = name;
    t_reg[row] = reg_idx;
    t_expected[row] = expected;
    t_pair[row] = pair;
    t_port[row] = port;
endtask

task automatic fill_table();
    set_row(0, "addi_pair", 2, 32'd9, pair_seen, 2'd2);
    t_prog[0] = '{addi(1, 0, 5), addi(2, 0, 9), nop, nop, nop, nop, nop, nop};
    set_row(1, "dependent_pair", 2, 32'd14, pair_never, 2'd0);
    t_prog[1] = '{addi(1, 0, 7), rtype(fn_add, 2, 1, 1), nop, nop, nop, nop, nop, nop};
    // Load must come back on wb2
    set_row(2, "store_then_load", 3, 32'hffffffb3, pair_any, 2'd2);
    t_prog[2] = '{addi(1, 0, 100), addi(2, 0, -77), sw(2, 1, 8), lw(3, 1, 8),
                  nop, nop, nop, nop};
    // Skipped words would leave x3 at 2 before the final add
    set_row(3, "beq_taken", 3, 32'd5, pair_any, 2'd0);
    t_prog[3] = '{addi(1, 0, 5), addi(2, 0, 5), beq(1, 2, 12), addi(3, 0, 1),
                  addi(3, 0, 2), rtype(fn_add, 3, 3, 1), nop, nop};
    set_row(4, "beq_not_taken", 3, 32'd8, pair_any, 2'd0);
    t_prog[4] = '{addi(1, 0, 5), addi(2, 0, 6), beq(1, 2, 12), addi(3, 0, 1),
                  addi(3, 3, 2), rtype(fn_add, 3, 3, 1), nop, nop};
    set_row(5, "beq_second_slot", 2, 32'd3, pair_any, 2'd0);
    t_prog[5] = '{addi(1, 0, 3), beq(0, 0, 12), addi(2, 0, 1), addi(2, 0, 2),
                  rtype(fn_add, 2, 2, 1), nop, nop, nop};
    set_row(6, "x0_write", 1, 32'd7, pair_any, 2'd0);
    t_prog[6] = '{addi(0, 0, 5), addi(0, 0, 6), addi(1, 0, 7), rtype(fn_add, 1, 1, 0),
                  nop, nop, nop, nop};
endtask

//--- testbench/core_tb.sv
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int prog_len = 8;
    localparam int load_words = 16;
    // Fetch pc that proves every program word has issued
    localparam int end_pc = 4 * prog_len + 8;
    localparam int random_rounds = 8;
    localparam int pair_any = 0;
    localparam int pair_seen = 1;
    localparam int pair_never = 2;

    localparam logic [9:0] fn_add = {f7_base, f3_add_sub};
    localparam logic [9:0] fn_sub = {f7_sub, f3_add_sub};
    localparam logic [9:0] fn_and = {f7_base, f3_and};
    localparam logic [9:0] fn_or = {f7_base, f3_or};
    localparam logic [9:0] fn_xor = {f7_base, f3_xor};
    localparam logic [9:0] fn_slt = {f7_base, f3_slt};
    localparam logic [xlen-1:0] nop = {12'd0, 5'd0, f3_add_sub, 5'd0, opc_op_imm};

    logic                       clk;
    logic                       reset;
    logic                       run;
    logic                       prog_we;
    logic [imem_addr_width-1:0] prog_addr;
    logic [xlen-1:0]            prog_data;
    logic [xlen-1:0]            pc;
    logic                       wb1_valid;
    logic [reg_addr_width-1:0]  wb1_rd;
    logic [xlen-1:0]            wb1_data;
    logic                       wb2_valid;
    logic [reg_addr_width-1:0]  wb2_rd;
    logic [xlen-1:0]            wb2_data;

    logic [xlen-1:0] cur_prog [prog_len];
    logic [xlen-1:0] model_regs [32];
    logic [xlen-1:0] shadow [32];
    logic [1:0]      last_port [32];
    logic            saw_pair;
    logic [15:0]     lfsr_state;
    string           cur_name;
    int              test_errors;
    int              pass_count;
    int              fail_count;
    int              run_cycles;

    dual_issue_core dual_issue_core_inst (.clk, .reset, .run, .prog_we, .prog_addr, .prog_data,
                                          .pc, .wb1_valid, .wb1_rd, .wb1_data, .wb2_valid,
                                          .wb2_rd, .wb2_data);

    function automatic logic [xlen-1:0] rtype(input logic [9:0] fn, input int rd, input int rs1,
                                              input int rs2);
        return {fn[9:3], 5'(rs2), 5'(rs1), fn[2:0], 5'(rd), opc_op};
    endfunction

    function automatic logic [xlen-1:0] addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3_add_sub, 5'(rd), opc_op_imm};
    endfunction

    function automatic logic [xlen-1:0] lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3_lw, 5'(rd), opc_load};
    endfunction

    function automatic logic [xlen-1:0] sw(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), f3_sw, i[4:0], opc_store};
    endfunction

    function automatic logic [xlen-1:0] beq(input int rs1, input int rs2, input int offset);
        logic [12:0] o;
        o = 13'(offset);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3_beq, o[4:1], o[11], opc_branch};
    endfunction

    // Filler no-op carries its own word address in the immediate
    function automatic logic [xlen-1:0] nop_at(input int addr);
        return addi(0, 0, addr);
    endfunction

    // Galois LFSR stepped once per bit
    function automatic logic [xlen-1:0] take_bits(input int count);
        logic [xlen-1:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[xlen-2:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic logic [9:0] random_fn();
        case (take_bits(3) % 6)
            0: return fn_add;
            1: return fn_sub;
            2: return fn_and;
            3: return fn_or;
            4: return fn_xor;
            default: return fn_slt;
        endcase
    endfunction

    `include "core_tests.svh"

    localparam int timeout_cycles = (num_directed + random_rounds) * 40;

    // Sequential ISA model for register ops and ADDI
    task automatic model_run();
        logic [xlen-1:0] r [32];
        logic [xlen-1:0] inst;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            inst = cur_prog[i];
            a = r[inst[19:15]];
            b = r[inst[24:20]];
            res = '0;
            if (inst[6:0] == opc_op_imm) begin
                res = a + {{20{inst[31]}}, inst[31:20]};
            end else if (inst[6:0] == opc_op) begin
                case ({inst[31:25], inst[14:12]})
                    fn_add: res = a + b;
                    fn_sub: res = a - b;
                    fn_and: res = a & b;
                    fn_or:  res = a | b;
                    fn_xor: res = a ^ b;
                    fn_slt: res = ($signed(a) < $signed(b)) ? xlen'(1) : '0;
                    default: res = '0;
                endcase
            end
            if (inst[11:7] != 5'd0) begin
                r[inst[11:7]] = res;
            end
        end
        model_regs = r;
    endtask

    // Two constants then four ops with chained dependencies
    task automatic build_random_round();
        cur_prog[0] = addi(1, 0, int'(take_bits(12)));
        cur_prog[1] = addi(2, 0, int'(take_bits(12)));
        cur_prog[2] = rtype(random_fn(), 3, 1, 2);
        cur_prog[3] = rtype(random_fn(), 4, 2, 1);
        cur_prog[4] = rtype(random_fn(), 5, 3, 1);
        cur_prog[5] = rtype(random_fn(), 6, 4, 5);
        cur_prog[6] = nop;
        cur_prog[7] = nop;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        run = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic load_program();
        for (int a = 0; a < load_words; a++) begin
            @(posedge clk);
            #1;
            prog_we = 1'b1;
            prog_addr = imem_addr_width'(a);
            prog_data = (a < prog_len) ? cur_prog[a] : nop_at(a);
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic record_retire();
        if (wb1_valid) begin
            if (wb1_rd == '0) begin
                $display("%s: a write to x0 retired as valid on wb1", cur_name);
                test_errors++;
            end
            shadow[wb1_rd] = wb1_data;
            last_port[wb1_rd] = 2'd1;
        end
        // wb2 holds the younger instruction of a pair
        if (wb2_valid) begin
            if (wb2_rd == '0) begin
                $display("%s: a write to x0 retired as valid on wb2", cur_name);
                test_errors++;
            end
            shadow[wb2_rd] = wb2_data;
            last_port[wb2_rd] = 2'd2;
        end
        if (wb1_valid && wb2_valid) begin
            saw_pair = 1'b1;
        end
    endtask

    task automatic run_program();
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
            last_port[r] = 2'd0;
        end
        saw_pair = 1'b0;
        @(posedge clk);
        #1;
        run = 1'b1;
        do begin
            @(negedge clk);
            record_retire();
        end while (pc < end_pc);
        @(negedge clk);
        record_retire();
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pairing(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s same-cycle retire expected %0b actual %0b", name, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic check_port(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s retire port expected wb%0d actual wb%0d", name, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", cur_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", cur_name, test_errors);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog counts only cycles in which the core runs
    always @(posedge clk) begin
        if (run) begin
            run_cycles = run_cycles + 1;
        end
        if (run_cycles > timeout_cycles) begin
            $display("Timeout: the core ran %0d cycles without finishing the tests", run_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run_cycles = 0;
        pass_count = 0;
        fail_count = 0;
        lfsr_state = 16'd24057;
        fill_table();
        for (int t = 0; t < num_directed; t++) begin
            cur_name = t_name[t];
            cur_prog = t_prog[t];
            test_errors = 0;
            apply_reset();
            check_data($sformatf("%s pc after reset", cur_name), '0, pc);
            load_program();
            run_program();
            check_data(cur_name, t_expected[t], shadow[t_reg[t]]);
            if (t_pair[t] != pair_any) begin
                check_pairing(cur_name, t_pair[t] == pair_seen, saw_pair);
            end
            if (t_port[t] != 2'd0) begin
                check_port(cur_name, t_port[t], last_port[t_reg[t]]);
            end
            report_test();
        end
        for (int k = 0; k < random_rounds; k++) begin
            cur_name = $sformatf("random_%0d", k);
            test_errors = 0;
            build_random_round();
            model_run();
            apply_reset();
            check_data($sformatf("%s pc after reset", cur_name), '0, pc);
            load_program();
            run_program();
            for (int r = 3; r <= 6; r++) begin
                check_data($sformatf("%s x%0d", cur_name, r), model_regs[r], shadow[r]);
            end
            report_test();
        end
        $display("tests %0d passed %0d failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- logic/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 run,
    input  logic                                 prog_we,
    input  logic [core_pkg::imem_addr_width-1:0] prog_addr,
    input  logic [core_pkg::xlen-1:0]            prog_data,
    output logic [core_pkg::xlen-1:0]            pc,
    output logic                                 wb1_valid,
    output logic [core_pkg::reg_addr_width-1:0]  wb1_rd,
    output logic [core_pkg::xlen-1:0]            wb1_data,
    output logic                                 wb2_valid,
    output logic [core_pkg::reg_addr_width-1:0]  wb2_rd,
    output logic [core_pkg::xlen-1:0]            wb2_data
);
    import core_pkg::*;

    logic [xlen-1:0]            inst1;
    logic [xlen-1:0]            inst2;
    logic [xlen-1:0]            fetch_pc;
    logic                       fetch_valid;
    logic [1:0]                 advance;
    logic                       redirect;
    logic [xlen-1:0]            redirect_pc;
    logic [dmem_addr_width-1:0] daddr;
    logic                       mem_we;
    logic                       mem_re;
    logic [xlen-1:0]            store_data;
    logic [xlen-1:0]            load_data;

    issue_lane_if lane1_if ();
    issue_lane_if lane2_if ();

    fetch_unit fetch (.clk, .reset, .run, .prog_we, .prog_addr, .prog_data, .advance,
                      .redirect, .redirect_pc, .inst1, .inst2, .fetch_pc, .fetch_valid, .pc);

    decode_issue decode (.clk, .reset, .inst1, .inst2, .fetch_pc, .fetch_valid, .advance,
                         .redirect, .redirect_pc, .daddr, .mem_we, .mem_re, .store_data,
                         .lane1(lane1_if), .lane2(lane2_if));

    // Only lane 2 carries memory operations
    alu_lane alu1 (.clk, .reset, .load_data('0), .lane(lane1_if));
    alu_lane alu2 (.clk, .reset, .load_data, .lane(lane2_if));

    data_memory dmem (.clk, .reset, .daddr, .mem_we, .mem_re, .store_data, .load_data);

    assign wb1_valid = lane1_if.result_valid;
    assign wb1_rd = lane1_if.result_rd;
    assign wb1_data = lane1_if.result;
    assign wb2_valid = lane2_if.result_valid;
    assign wb2_rd = lane2_if.result_rd;
    assign wb2_data = lane2_if.result;

endmodule

//--- logic/data_memory.sv
`timescale 1ns/10ps

module data_memory (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [core_pkg::dmem_addr_width-1:0] daddr,
    input  logic                                 mem_we,
    input  logic                                 mem_re,
    input  logic [core_pkg::xlen-1:0]            store_data,
    output logic [core_pkg::xlen-1:0]            load_data
);
    import core_pkg::*;

    logic [xlen-1:0] mem [dmem_depth];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[daddr] <= store_data;
        end
    end

    // Read data lines up with the lane 2 result register
    always_ff @(posedge clk) begin
        if (reset) begin
            load_data <= '0;
        end else if (mem_re) begin
            load_data <= mem[daddr];
        end
    end

endmodule

//--- logic/alu_lane.sv
`timescale 1ns/10ps

module alu_lane (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [core_pkg::xlen-1:0] load_data,
    issue_lane_if.execute             lane
);
    import core_pkg::*;

    logic [xlen-1:0]           alu_out;
    logic [xlen-1:0]           alu_reg;
    logic [reg_addr_width-1:0] rd_reg;
    logic                      valid_reg;
    logic                      load_reg;

    always_comb begin
        case (lane.alu_op)
            alu_add: alu_out = lane.op1 + lane.op2;
            alu_sub: alu_out = lane.op1 - lane.op2;
            alu_and: alu_out = lane.op1 & lane.op2;
            alu_or:  alu_out = lane.op1 | lane.op2;
            alu_xor: alu_out = lane.op1 ^ lane.op2;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(lane.op1) < $signed(lane.op2)};
            default: alu_out = lane.op2;
        endcase
    end

    // Writes to x0 never retire
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_reg <= 1'b0;
            load_reg <= 1'b0;
        end else begin
            valid_reg <= lane.valid && (lane.rd != '0);
            load_reg <= lane.valid && lane.mem_read;
        end
    end

    always_ff @(posedge clk) begin
        alu_reg <= alu_out;
        rd_reg <= lane.rd;
    end

    assign lane.result = load_reg ? load_data : alu_reg;
    assign lane.result_rd = rd_reg;
    assign lane.result_valid = valid_reg;

endmodule

//--- logic/decode_issue.sv
`timescale 1ns/10ps

module decode_issue (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [core_pkg::xlen-1:0]            inst1,
    input  logic [core_pkg::xlen-1:0]            inst2,
    input  logic [core_pkg::xlen-1:0]            fetch_pc,
    input  logic                                 fetch_valid,
    output logic [1:0]                           advance,
    output logic                                 redirect,
    output logic [core_pkg::xlen-1:0]            redirect_pc,
    output logic [core_pkg::dmem_addr_width-1:0] daddr,
    output logic                                 mem_we,
    output logic                                 mem_re,
    output logic [core_pkg::xlen-1:0]            store_data,
    issue_lane_if.issue                          lane1,
    issue_lane_if.issue                          lane2
);
    import core_pkg::*;

    typedef struct packed {
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
        logic                      uses_rs1;
        logic                      uses_rs2;
        logic                      use_imm;
        logic                      is_load;
        logic                      is_store;
        logic                      is_branch;
        alu_op_t                   alu_op;
        logic [xlen-1:0]           imm;
    } dec_t;

    // rd stays zero for anything that does not write a register
    function automatic dec_t decode_inst(input logic [xlen-1:0] inst);
        dec_t       d;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        opcode = inst[6:0];
        funct3 = inst[14:12];
        funct7 = inst[31:25];
        d = '0;
        d.rs1 = inst[19:15];
        d.rs2 = inst[24:20];
        d.alu_op = alu_pass;
        case (opcode)
            opc_op: begin
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
                d.rd = inst[11:7];
                case (funct3)
                    f3_add_sub: d.alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_slt:     d.alu_op = alu_slt;
                    f3_xor:     d.alu_op = alu_xor;
                    f3_or:      d.alu_op = alu_or;
                    f3_and:     d.alu_op = alu_and;
                    default:    d.rd = '0;
                endcase
                if (funct7 != f7_base && !(funct7 == f7_sub && funct3 == f3_add_sub)) begin
                    d.rd = '0;
                end
            end
            opc_op_imm: begin
                if (funct3 == f3_add_sub) begin
                    d.uses_rs1 = 1'b1;
                    d.use_imm = 1'b1;
                    d.rd = inst[11:7];
                    d.alu_op = alu_add;
                    d.imm = {{20{inst[31]}}, inst[31:20]};
                end
            end
            opc_load: begin
                if (funct3 == f3_lw) begin
                    d.uses_rs1 = 1'b1;
                    d.use_imm = 1'b1;
                    d.is_load = 1'b1;
                    d.rd = inst[11:7];
                    d.imm = {{20{inst[31]}}, inst[31:20]};
                end
            end
            opc_store: begin
                if (funct3 == f3_sw) begin
                    d.uses_rs1 = 1'b1;
                    d.uses_rs2 = 1'b1;
                    d.is_store = 1'b1;
                    d.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
            end
            opc_branch: begin
                if (funct3 == f3_beq) begin
                    d.uses_rs1 = 1'b1;
                    d.uses_rs2 = 1'b1;
                    d.is_branch = 1'b1;
                    d.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        return d;
    endfunction

    logic [xlen-1:0]           regs [2**reg_addr_width];
    dec_t                      d1;
    dec_t                      d2;
    dec_t                      dl;
    logic [reg_addr_width-1:0] src [4];
    logic [xlen-1:0]           opnd [4];
    logic [xlen-1:0]           al;
    logic [xlen-1:0]           bl;
    logic [xlen-1:0]           mem_addr;
    logic                      dep;
    logic                      pair;

    assign d1 = decode_inst(inst1);
    assign d2 = decode_inst(inst2);

    assign src[0] = d1.rs1;
    assign src[1] = d1.rs2;
    assign src[2] = d2.rs1;
    assign src[3] = d2.rs2;

    // Lane 2 holds the younger result when both match
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (src[i] == '0) begin
                opnd[i] = '0;
            end else if (lane2.result_valid && lane2.result_rd == src[i]) begin
                opnd[i] = lane2.result;
            end else if (lane1.result_valid && lane1.result_rd == src[i]) begin
                opnd[i] = lane1.result;
            end else begin
                opnd[i] = regs[src[i]];
            end
        end
    end

    // Pairing check
    assign dep = (d1.rd != '0) && ((d2.uses_rs1 && d2.rs1 == d1.rd) ||
                                   (d2.uses_rs2 && d2.rs2 == d1.rd));
    assign pair = !dep && !d1.is_load && !d1.is_store && !d1.is_branch;
    assign advance = !fetch_valid ? 2'd0 : (pair ? 2'd2 : 2'd1);

    // Last instruction issued this cycle owns lane 2 and any branch
    assign dl = pair ? d2 : d1;
    assign al = pair ? opnd[2] : opnd[0];
    assign bl = pair ? opnd[3] : opnd[1];

    assign lane1.valid = fetch_valid && !d1.is_load && !d1.is_store;
    assign lane1.op1 = opnd[0];
    assign lane1.op2 = d1.use_imm ? d1.imm : opnd[1];
    assign lane1.alu_op = d1.alu_op;
    assign lane1.rd = d1.rd;
    assign lane1.mem_read = 1'b0;

    assign lane2.valid = fetch_valid && (pair || d1.is_load || d1.is_store);
    assign lane2.op1 = al;
    assign lane2.op2 = dl.use_imm ? dl.imm : bl;
    assign lane2.alu_op = dl.alu_op;
    assign lane2.rd = dl.rd;
    assign lane2.mem_read = dl.is_load;

    assign mem_addr = al + dl.imm;
    assign daddr = mem_addr[dmem_addr_width+1:2];
    assign mem_re = fetch_valid && dl.is_load;
    assign mem_we = fetch_valid && dl.is_store;
    assign store_data = bl;

    // BEQ resolves here
    assign redirect = fetch_valid && dl.is_branch && (al == bl);
    assign redirect_pc = (pair ? fetch_pc + xlen'(4) : fetch_pc) + dl.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (lane1.result_valid && lane1.result_rd != '0) begin
                regs[lane1.result_rd] <= lane1.result;
            end
            if (lane2.result_valid && lane2.result_rd != '0) begin
                regs[lane2.result_rd] <= lane2.result;
            end
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 run,
    input  logic                                 prog_we,
    input  logic [core_pkg::imem_addr_width-1:0] prog_addr,
    input  logic [core_pkg::xlen-1:0]            prog_data,
    input  logic [1:0]                           advance,
    input  logic                                 redirect,
    input  logic [core_pkg::xlen-1:0]            redirect_pc,
    output logic [core_pkg::xlen-1:0]            inst1,
    output logic [core_pkg::xlen-1:0]            inst2,
    output logic [core_pkg::xlen-1:0]            fetch_pc,
    output logic                                 fetch_valid,
    output logic [core_pkg::xlen-1:0]            pc
);
    import core_pkg::*;

    logic [xlen-1:0]            imem [imem_depth];
    logic [xlen-1:0]            next_pc;
    logic [imem_addr_width-1:0] word0;
    logic [imem_addr_width-1:0] word1;

    // Step past the words decode issued this cycle
    assign next_pc = pc + {{(xlen-4){1'b0}}, advance, 2'b00};
    assign word0 = next_pc[imem_addr_width+1:2];
    assign word1 = word0 + 1'b1;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        inst1 <= imem[word0];
        inst2 <= imem[word1];
    end

    // Bundle in flight is dropped on redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (redirect) begin
            pc <= redirect_pc;
            fetch_valid <= 1'b0;
        end else begin
            pc <= next_pc;
            fetch_valid <= run;
        end
    end

    // pc always tracks the bundle held for decode
    assign fetch_pc = pc;

endmodule

//--- logic/issue_lane_if.sv
`timescale 1ns/10ps

interface issue_lane_if;
    import core_pkg::*;

    logic                      valid;
    logic [xlen-1:0]           op1;
    logic [xlen-1:0]           op2;
    alu_op_t                   alu_op;
    logic [reg_addr_width-1:0] rd;
    logic                      mem_read;

    // Result registered one cycle after issue
    logic [xlen-1:0]           result;
    logic [reg_addr_width-1:0] result_rd;
    logic                      result_valid;

    modport issue (
        output valid, op1, op2, alu_op, rd, mem_read,
        input  result, result_rd, result_valid
    );

    modport execute (
        input  valid, op1, op2, alu_op, rd, mem_read,
        output result, result_rd, result_valid
    );

endinterface

//--- logic/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    localparam int imem_depth = 256;
    localparam int imem_addr_width = 8;
    localparam int dmem_depth = 256;
    localparam int dmem_addr_width = 8;

    // pass forwards op2 unchanged
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass
    } alu_op_t;

    // RV32I major opcodes
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_sw = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;

endpackage
